// File: rtl/x25519_pkg.sv
package x25519_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field GF(2^255 - 19) of the curve

	localparam int FE_BITS = 256;	// One full word per element

	// Canonical element held below p
	typedef logic [FE_BITS-1:0] fe_t;

	// p = 2^255 - 19
	localparam fe_t P25519 = {
		64'h7fff_ffff_ffff_ffff,
		64'hffff_ffff_ffff_ffff,
		64'hffff_ffff_ffff_ffff,
		64'hffff_ffff_ffff_ffed
	};

	// (A - 2) / 4 for the Montgomery curve with A = 486662
	localparam fe_t A24 = fe_t'(121665);

	////////////////////////////////////////////////////////////////////////////
	// Points and scalars

	// Projective point with x first
	typedef struct packed {
		fe_t x;
		fe_t z;
	} xz_t;

	typedef logic [255:0] scalar_t;	// Caller scalar with clamping done outside

	typedef logic [7:0] bit_idx_t;	// Selects one scalar bit

	// Ladder walks from here down to bit 0
	localparam bit_idx_t LADDER_TOP_BIT = 8'd254;

	////////////////////////////////////////////////////////////////////////////
	// Arithmetic timing

	// One multiplier bit per clock from the MSB down
	localparam int MULT_CYCLES = 256;

	// Add/sub latency is fixed at one cycle
	// Multiply latency is MULT_CYCLES + 1 from en to valid
	// A full ladder step issues ten multiplies back to back

endpackage

// File: rtl/fe_addsub.sv
`timescale 1ns/10ps

module fe_addsub (
	input  logic            clk,
	input  logic            rst,
	input  logic            en,
	input  x25519_pkg::fe_t a,
	input  x25519_pkg::fe_t b,
	output logic            valid,
	output x25519_pkg::fe_t sum,
	output x25519_pkg::fe_t diff
);

	// One extra bit for carry and borrow
	logic [x25519_pkg::FE_BITS:0] sum_raw;	// a + b, below 2p
	logic [x25519_pkg::FE_BITS:0] sum_red;	// a + b - p
	logic [x25519_pkg::FE_BITS:0] diff_raw;	// a - b, MSB is the borrow

	always_comb begin
		sum_raw  = {1'b0, a} + {1'b0, b};
		sum_red  = sum_raw - {1'b0, x25519_pkg::P25519};
		diff_raw = {1'b0, a} - {1'b0, b};
	end

	// Valid strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= 1'b0;
		end else begin
			valid <= en;
		end
	end

	// Results
	always_ff @(posedge clk) begin
		if (en) begin
			// Borrow out of sum_red means the sum was already below p
			sum  <= sum_red[x25519_pkg::FE_BITS] ? sum_raw[x25519_pkg::FE_BITS-1:0]
			                                     : sum_red[x25519_pkg::FE_BITS-1:0];
			// Wrap negative differences back into range
			diff <= diff_raw[x25519_pkg::FE_BITS]
			        ? diff_raw[x25519_pkg::FE_BITS-1:0] + x25519_pkg::P25519
			        : diff_raw[x25519_pkg::FE_BITS-1:0];
		end
	end

endmodule

// File: rtl/fe_mult.sv
`timescale 1ns/10ps

module fe_mult (
	input  logic            clk,
	input  logic            rst,
	input  logic            en,
	input  x25519_pkg::fe_t a,
	input  x25519_pkg::fe_t b,
	output logic            valid,
	output x25519_pkg::fe_t prod,
	output logic            busy
);

	x25519_pkg::fe_t a_r;	// Multiplicand, held for the run
	x25519_pkg::fe_t b_r;	// Multiplier, MSB consumed each cycle
	x25519_pkg::fe_t acc;	// Partial product, kept below p

	logic [$clog2(x25519_pkg::MULT_CYCLES)-1:0] cnt;	// Bits done so far

	logic [x25519_pkg::FE_BITS:0] dbl_add;	// 2*acc (+ a), below 3p
	logic [x25519_pkg::FE_BITS:0] red1;	// Below 2p
	logic [x25519_pkg::FE_BITS:0] red2;	// Below p

	////////////////////////////////////////////////////////////////////////////
	// Double, add and reduce

	always_comb begin
		dbl_add = {acc, 1'b0} +
			(b_r[x25519_pkg::FE_BITS-1] ? {1'b0, a_r} : '0);
		red1 = (dbl_add >= {1'b0, x25519_pkg::P25519}) ?
			dbl_add - {1'b0, x25519_pkg::P25519} : dbl_add;
		red2 = (red1 >= {1'b0, x25519_pkg::P25519}) ?
			red1 - {1'b0, x25519_pkg::P25519} : red1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Iteration control

	always_ff @(posedge clk) begin
		if (rst) begin
			busy  <= 1'b0;
			valid <= 1'b0;
			cnt   <= '0;
		end else begin
			valid <= 1'b0;
			if (en) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (int'(cnt) == x25519_pkg::MULT_CYCLES - 1) begin
					busy  <= 1'b0;	// Last bit, result lands with valid
					valid <= 1'b1;
				end
			end
		end
	end

	// Datapath registers
	always_ff @(posedge clk) begin
		if (en) begin
			a_r <= a;
			b_r <= b;
			acc <= '0;
		end else if (busy) begin
			acc <= red2[x25519_pkg::FE_BITS-1:0];
			b_r <= b_r << 1;
		end
	end

	assign prod = acc;	// Frozen once busy drops

	// Caller must wait for valid before the next operand pair
	a_no_overlap: assert property (@(posedge clk) disable iff (rst) en |-> !busy);

endmodule

// File: rtl/ladder_step.sv
`timescale 1ns/10ps

module ladder_step (
	input  logic            clk,
	input  logic            rst,
	input  logic            en,
	input  x25519_pkg::xz_t cur,
	input  x25519_pkg::xz_t nxt,
	input  logic            swap_bit,
	input  x25519_pkg::fe_t x1,
	output logic            done,
	output x25519_pkg::xz_t cur_out,
	output x25519_pkg::xz_t nxt_out
);

	////////////////////////////////////////////////////////////////////////////
	// Microcode format

	// One state per issue group
	typedef enum logic [3:0] {
		S_IDLE, S_AB, S_CD, S_BB, S_DA, S_CB, S_X2, S_E24, S_X3, S_Z2, S_SQ, S_Z3
	} step_state_t;

	typedef enum logic [3:0] {
		R_T0 = 4'd0, R_T1, R_T2, R_T3, R_T4, R_T5,	// Temporaries
		R_X2 = 4'd8, R_Z2, R_X3, R_Z3,			// Inputs after swap
		R_X1 = 4'd12,
		R_A24 = 4'd13,
		R_NONE = 4'd15					// Result dropped
	} reg_id_t;

	typedef struct packed {
		logic        as_go;	// Issue add/sub on entry
		logic        mul_go;	// Issue multiply on entry
		reg_id_t     as_a;
		reg_id_t     as_b;
		reg_id_t     mul_a;
		reg_id_t     mul_b;
		reg_id_t     sum_dst;
		reg_id_t     diff_dst;
		reg_id_t     prod_dst;
		logic        adv_mul;	// Wait for mul_valid when set
		step_state_t next;
	} ucode_t;

	step_state_t state;
	ucode_t      line;
	logic        issue;	// First cycle in a state
	logic        advance;

	x25519_pkg::xz_t p2;	// (x2, z2) after input swap
	x25519_pkg::xz_t p3;	// (x3, z3) after input swap
	x25519_pkg::fe_t x1_r;
	logic            swap_r;
	x25519_pkg::fe_t tmp [6];

	logic            as_en;
	logic            as_valid;
	x25519_pkg::fe_t as_a;
	x25519_pkg::fe_t as_b;
	x25519_pkg::fe_t as_sum;
	x25519_pkg::fe_t as_diff;
	logic            mul_en;
	logic            mul_valid;
	logic            mul_busy;
	x25519_pkg::fe_t mul_a;
	x25519_pkg::fe_t mul_b;
	x25519_pkg::fe_t mul_prod;

	fe_addsub u_addsub (
		.clk(clk), .rst(rst), .en(as_en), .a(as_a), .b(as_b),
		.valid(as_valid), .sum(as_sum), .diff(as_diff)
	);

	fe_mult u_mult (
		.clk(clk), .rst(rst), .en(mul_en), .a(mul_a), .b(mul_b),
		.valid(mul_valid), .prod(mul_prod), .busy(mul_busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// ROM

	always_comb begin
		case (state)
			// as_go mul_go  as_a as_b  mul_a mul_b  sum diff prod  adv_mul next
			S_AB:    line = '{1'b1, 1'b0, R_X2, R_Z2, R_NONE, R_NONE,
				R_T0, R_T1, R_NONE, 1'b0, S_CD};	// A, B
			S_CD:    line = '{1'b1, 1'b1, R_X3, R_Z3, R_T0, R_T0,
				R_T2, R_T3, R_T4, 1'b1, S_BB};		// C, D, AA
			S_BB:    line = '{1'b0, 1'b1, R_NONE, R_NONE, R_T1, R_T1,
				R_NONE, R_NONE, R_T5, 1'b1, S_DA};	// BB
			S_DA:    line = '{1'b1, 1'b1, R_T4, R_T5, R_T3, R_T0,
				R_NONE, R_T3, R_T0, 1'b1, S_CB};	// E over D, DA over A
			S_CB:    line = '{1'b0, 1'b1, R_NONE, R_NONE, R_T2, R_T1,
				R_NONE, R_NONE, R_T1, 1'b1, S_X2};	// CB over B
			S_X2:    line = '{1'b1, 1'b1, R_T0, R_T1, R_T4, R_T5,
				R_T0, R_T1, R_T2, 1'b1, S_E24};	// DA+CB, DA-CB, x2'
			S_E24:   line = '{1'b0, 1'b1, R_NONE, R_NONE, R_T3, R_A24,
				R_NONE, R_NONE, R_T5, 1'b1, S_X3};
			S_X3:    line = '{1'b1, 1'b1, R_T4, R_T5, R_T0, R_T0,
				R_T4, R_NONE, R_T0, 1'b1, S_Z2};	// AA + A24*E, x3'
			S_Z2:    line = '{1'b0, 1'b1, R_NONE, R_NONE, R_T3, R_T4,
				R_NONE, R_NONE, R_T3, 1'b1, S_SQ};	// z2'
			S_SQ:    line = '{1'b0, 1'b1, R_NONE, R_NONE, R_T1, R_T1,
				R_NONE, R_NONE, R_T1, 1'b1, S_Z3};
			S_Z3:    line = '{1'b0, 1'b1, R_NONE, R_NONE, R_T1, R_X1,
				R_NONE, R_NONE, R_T1, 1'b1, S_IDLE};	// z3'
			default: line = '{1'b0, 1'b0, R_NONE, R_NONE, R_NONE, R_NONE,
				R_NONE, R_NONE, R_NONE, 1'b0, S_IDLE};
		endcase
	end

	// Operand fetch, special ids first
	function automatic x25519_pkg::fe_t rd(input reg_id_t id);
		case (id)
			R_X2:    rd = p2.x;
			R_Z2:    rd = p2.z;
			R_X3:    rd = p3.x;
			R_Z3:    rd = p3.z;
			R_X1:    rd = x1_r;
			R_A24:   rd = x25519_pkg::A24;
			R_NONE:  rd = '0;
			default: rd = tmp[id[2:0]];
		endcase
	endfunction

	always_comb begin
		as_en   = issue & line.as_go;
		mul_en  = issue & line.mul_go;
		as_a    = rd(line.as_a);
		as_b    = rd(line.as_b);
		mul_a   = rd(line.mul_a);
		mul_b   = rd(line.mul_b);
		advance = (state != S_IDLE) && (line.adv_mul ? mul_valid : as_valid);
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			issue <= 1'b0;
			done  <= 1'b0;
		end else begin
			issue <= 1'b0;
			done  <= 1'b0;
			if (en && state == S_IDLE) begin
				state <= S_AB;
				issue <= 1'b1;
			end else if (advance) begin
				state <= line.next;
				issue <= (line.next != S_IDLE);
				done  <= (line.next == S_IDLE);	// Temps final next cycle
			end
		end
	end

	// Input swap and writeback
	always_ff @(posedge clk) begin
		if (en && state == S_IDLE) begin
			p2     <= swap_bit ? nxt : cur;
			p3     <= swap_bit ? cur : nxt;
			x1_r   <= x1;
			swap_r <= swap_bit;
		end
		if (as_valid && line.sum_dst <= R_T5) begin
			tmp[line.sum_dst[2:0]] <= as_sum;
		end
		if (as_valid && line.diff_dst <= R_T5) begin
			tmp[line.diff_dst[2:0]] <= as_diff;
		end
		if (mul_valid && line.prod_dst <= R_T5) begin
			tmp[line.prod_dst[2:0]] <= mul_prod;
		end
	end

	// Swap back, x2'/z2' in T2/T3 and x3'/z3' in T0/T1
	always_comb begin
		if (swap_r) begin
			cur_out = {tmp[0], tmp[1]};
			nxt_out = {tmp[2], tmp[3]};
		end else begin
			cur_out = {tmp[2], tmp[3]};
			nxt_out = {tmp[0], tmp[1]};
		end
	end

	// New step only from idle, with the shared multiplier drained
	a_en_idle: assert property (@(posedge clk) disable iff (rst)
		en |-> (state == S_IDLE) && !mul_busy);

endmodule

// File: rtl/ladder_ctrl.sv
`timescale 1ns/10ps

module ladder_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  x25519_pkg::scalar_t scalar,
	input  x25519_pkg::fe_t     u,
	output logic                busy,
	output logic                done,
	output x25519_pkg::xz_t     result,
	output logic                step_en,
	output logic                swap_bit,
	output x25519_pkg::fe_t     x1,
	output x25519_pkg::xz_t     cur,
	output x25519_pkg::xz_t     nxt,
	input  logic                step_done,
	input  x25519_pkg::xz_t     cur_out,
	input  x25519_pkg::xz_t     nxt_out
);

	typedef enum logic {C_IDLE, C_RUN} ctrl_state_t;

	ctrl_state_t          state;
	x25519_pkg::scalar_t  scalar_r;
	x25519_pkg::bit_idx_t bit_idx;	// Bit being processed

	assign busy     = (state == C_RUN);
	assign swap_bit = scalar_r[bit_idx];
	assign result   = cur;	// Held until the next start

	// Bit scanner
	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= C_IDLE;
			step_en <= 1'b0;
			done    <= 1'b0;
			bit_idx <= '0;
		end else begin
			step_en <= 1'b0;
			done    <= 1'b0;
			case (state)
				C_IDLE: if (start) begin
					state   <= C_RUN;
					step_en <= 1'b1;	// First step with the top bit
					bit_idx <= x25519_pkg::LADDER_TOP_BIT;
				end
				C_RUN: if (step_done) begin
					if (bit_idx == '0) begin
						state <= C_IDLE;	// Bit 0 done
						done  <= 1'b1;
					end else begin
						bit_idx <= bit_idx - 1'b1;
						step_en <= 1'b1;
					end
				end
				default: state <= C_IDLE;
			endcase
		end
	end

	// Ladder state, starts at (1:0) and (u:1)
	always_ff @(posedge clk) begin
		if (start && state == C_IDLE) begin
			scalar_r <= scalar;
			x1       <= u;
			cur      <= {x25519_pkg::fe_t'(1), x25519_pkg::fe_t'(0)};
			nxt      <= {u, x25519_pkg::fe_t'(1)};
		end else if (step_done && state == C_RUN) begin
			cur <= cur_out;
			nxt <= nxt_out;
		end
	end

	a_bit_range: assert property (@(posedge clk) disable iff (rst)
		busy |-> bit_idx <= x25519_pkg::LADDER_TOP_BIT);

endmodule

// File: rtl/x25519_ladder.sv
`timescale 1ns/10ps

module x25519_ladder (
	input  logic                clk,
	input  logic                rst,
	input  logic                start,
	input  x25519_pkg::scalar_t scalar,
	input  x25519_pkg::fe_t     u,
	output logic                busy,
	output logic                done,
	output x25519_pkg::xz_t     result
);

	// Controller to step engine
	logic            step_en;
	logic            step_done;
	logic            swap_bit;
	x25519_pkg::fe_t x1;
	x25519_pkg::xz_t cur;
	x25519_pkg::xz_t nxt;
	x25519_pkg::xz_t cur_out;
	x25519_pkg::xz_t nxt_out;

	ladder_ctrl u_ctrl (
		.clk(clk), .rst(rst), .start(start), .scalar(scalar), .u(u),
		.busy(busy), .done(done), .result(result),
		.step_en(step_en), .swap_bit(swap_bit), .x1(x1), .cur(cur), .nxt(nxt),
		.step_done(step_done), .cur_out(cur_out), .nxt_out(nxt_out)
	);

	ladder_step u_step (
		.clk(clk), .rst(rst), .en(step_en), .cur(cur), .nxt(nxt),
		.swap_bit(swap_bit), .x1(x1),
		.done(step_done), .cur_out(cur_out), .nxt_out(nxt_out)
	);

endmodule

// File: bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Field arithmetic mod 2^255 - 19, straight from the definitions

function automatic x25519_pkg::fe_t fe_add(input x25519_pkg::fe_t a, input x25519_pkg::fe_t b);
	logic [256:0] s;
	s = {1'b0, a} + {1'b0, b};
	s = s % {1'b0, x25519_pkg::P25519};
	return s[255:0];
endfunction

function automatic x25519_pkg::fe_t fe_sub(input x25519_pkg::fe_t a, input x25519_pkg::fe_t b);
	logic [256:0] s;
	s = {1'b0, a} + {1'b0, x25519_pkg::P25519} - {1'b0, b};	// Never negative
	s = s % {1'b0, x25519_pkg::P25519};
	return s[255:0];
endfunction

function automatic x25519_pkg::fe_t fe_mul(input x25519_pkg::fe_t a, input x25519_pkg::fe_t b);
	logic [511:0] w;	// Full double width product
	w = {256'b0, a} * {256'b0, b};
	w = w % {256'b0, x25519_pkg::P25519};
	return w[255:0];
endfunction

////////////////////////////////////////////////////////////////////////////
// Ladder

// Differential add and double, p2 doubles and p3 becomes p2 + p3
function automatic void ladder_rung(input x25519_pkg::fe_t x1,
	inout x25519_pkg::xz_t p2, inout x25519_pkg::xz_t p3);
	x25519_pkg::fe_t a, b, c, d, aa, bb, e, da, cb, t;
	a  = fe_add(p2.x, p2.z);
	b  = fe_sub(p2.x, p2.z);
	c  = fe_add(p3.x, p3.z);
	d  = fe_sub(p3.x, p3.z);
	aa = fe_mul(a, a);
	bb = fe_mul(b, b);
	e  = fe_sub(aa, bb);
	da = fe_mul(d, a);
	cb = fe_mul(c, b);
	t  = fe_add(da, cb);
	p3.x = fe_mul(t, t);
	t  = fe_sub(da, cb);
	p3.z = fe_mul(x1, fe_mul(t, t));
	p2.x = fe_mul(aa, bb);
	p2.z = fe_mul(e, fe_add(aa, fe_mul(x25519_pkg::A24, e)));
endfunction

// Bits 254 down to 0, swap in and out by each bit
function automatic x25519_pkg::xz_t expected_ladder(input x25519_pkg::scalar_t k,
	input x25519_pkg::fe_t u);
	x25519_pkg::xz_t p2, p3, t;
	x25519_pkg::bit_idx_t bi;
	int i;
	p2.x = 256'd1;	// Point at infinity
	p2.z = '0;
	p3.x = u;	// Base point
	p3.z = 256'd1;
	for (i = 254; i >= 0; i--) begin
		bi = i[7:0];
		if (k[bi]) begin
			t  = p2;
			p2 = p3;
			p3 = t;
		end
		ladder_rung(u, p2, p3);
		if (k[bi]) begin
			t  = p2;
			p2 = p3;
			p3 = t;
		end
	end
	return p2;
endfunction

`endif

// File: bench/tb_x25519_ladder.sv
`timescale 1ns/10ps

module tb_x25519_ladder;

	localparam int N_ENTRIES   = 6;
	localparam int RUN_TIMEOUT = 1000000;	// Cycles, a run takes about 670k
	localparam int POKE_CYCLE  = 200;	// Stray start lands in the first step

	typedef struct packed {
		x25519_pkg::scalar_t scalar;
		x25519_pkg::fe_t     u;
		int                  gap;	// Idle cycles before start, 0 is back to back
		logic                poke;	// Extra start while busy
		logic [1:0]          zchk;	// 1 z2 nonzero, 2 z2 zero
	} entry_t;

	logic                clk;
	logic                rst;
	logic                start;
	x25519_pkg::scalar_t scalar;
	x25519_pkg::fe_t     u;
	logic                busy;
	logic                done;
	x25519_pkg::xz_t     result;

	entry_t tbl [N_ENTRIES];
	int     seed;
	int     errors;
	int     checks;

	x25519_ladder uut (
		.clk(clk), .rst(rst), .start(start), .scalar(scalar), .u(u),
		.busy(busy), .done(done), .result(result)
	);

	`include "tb_model.svh"

	always #2 clk = ~clk;	// 4 ns period

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_xz(input string name, input x25519_pkg::xz_t got,
		input x25519_pkg::xz_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t %s got x=%h z=%h expected x=%h z=%h",
				$time, name, got.x, got.z, exp.x, exp.z);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	function automatic logic [255:0] rand_word();
		logic [255:0] w;
		int k;
		w = '0;
		for (k = 0; k < 8; k++) w = {w[223:0], $random(seed)};
		return w;
	endfunction

	task automatic fill_table();
		tbl[0] = '{256'd1, 256'd9, 2, 1'b0, 2'd1};	// Single add of the base
		tbl[1] = '{256'd0, 256'd9, 0, 1'b1, 2'd2};	// Infinity, poked mid-run
		tbl[2] = '{{64{4'h5}}, x25519_pkg::P25519 - 256'd1, 0, 1'b0, 2'd0};
		tbl[3] = '{'1, 256'd2, 3, 1'b0, 2'd0};	// Swap on every bit
		tbl[4] = '{rand_word(), rand_word() % x25519_pkg::P25519, 0, 1'b1, 2'd0};
		tbl[5] = '{rand_word(), rand_word() % x25519_pkg::P25519, 1, 1'b0, 2'd0};
	endtask

	// Quiet cycles, nothing may move
	task automatic idle_check(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			check_bit("busy", busy, 1'b0);
			check_bit("done", done, 1'b0);
		end
	endtask

	task automatic run_entry(input int idx, output bit ok);
		x25519_pkg::xz_t exp_xz;
		int cycles;
		bit busy_bad;
		exp_xz   = expected_ladder(tbl[idx].scalar, tbl[idx].u);
		ok       = 1'b0;
		busy_bad = 1'b0;
		idle_check(tbl[idx].gap);
		start  = 1'b1;
		scalar = tbl[idx].scalar;
		u      = tbl[idx].u;
		@(posedge clk);
		#1;
		start  = 1'b0;
		scalar = ~tbl[idx].scalar;	// Core must use its latched copy
		u      = '0;
		check_bit("busy", busy, 1'b1);
		check_bit("done", done, 1'b0);
		for (cycles = 1; cycles <= RUN_TIMEOUT && !ok; cycles++) begin
			start = tbl[idx].poke && cycles == POKE_CYCLE;
			@(posedge clk);
			#1;
			if (done) begin
				ok = 1'b1;
			end else if (!busy_bad) begin
				check_bit("busy", busy, 1'b1);	// One report per run at most
				busy_bad = (busy !== 1'b1);
			end
		end
		start = 1'b0;
		if (ok) begin
			check_bit("busy", busy, 1'b0);	// Falls with done
			check_xz("result", result, exp_xz);
			if (tbl[idx].zchk == 2'd1 && result.z == '0) begin
				errors++;
				$display("ERROR: entry %0d gave z2 of zero for a finite point", idx);
			end
			if (tbl[idx].zchk == 2'd2 && result.z != '0) begin
				errors++;
				$display("ERROR: entry %0d gave a nonzero z2 for scalar zero", idx);
			end
		end else begin
			errors++;
			$display("ERROR: entry %0d never raised done within %0d cycles", idx, RUN_TIMEOUT);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int i;
		bit ok;
		clk    = 1'b0;
		rst    = 1'b1;
		start  = 1'b0;
		scalar = '0;
		u      = '0;
		errors = 0;
		checks = 0;
		seed   = 32'h9dcc_a92d;
		fill_table();
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		idle_check(8);	// No start, nothing happens
		ok = 1'b1;
		for (i = 0; i < N_ENTRIES && ok; i++) begin
			run_entry(i, ok);
		end
		if (ok) idle_check(4);	// Single done pulse at the end
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the X25519 ladder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_x25519_ladder \
	-Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_x25519_ladder)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
	exit 0
fi
exit 1

// File: flist.f
+incdir+bench
rtl/x25519_pkg.sv
rtl/fe_addsub.sv
rtl/fe_mult.sv
rtl/ladder_step.sv
rtl/ladder_ctrl.sv
rtl/x25519_ladder.sv
bench/tb_x25519_ladder.sv
